// ==== soc_pkg.sv ====
package soc_pkg;

    localparam int MEM_DEPTH = 32;                  // instruction words
    localparam int ADDR_W    = $clog2(MEM_DEPTH);

    typedef enum logic [3:0] {
        op_ldi  = 4'h1,
        op_add  = 4'h2,
        op_sub  = 4'h3,
        op_rsw  = 4'h4,
        op_out  = 4'h5,
        op_jnz  = 4'h6,
        op_halt = 4'h7
    } opcode_e;                                     // other codes act as nop

    typedef struct packed {
        opcode_e    op;
        logic [3:0] rsvd;
        logic [7:0] imm;                            // zero-extended on use
    } instr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        instr_t            instr;
    } load_rec_t;

    typedef logic [15:0] disp_t;
    typedef logic [6:0]  seg_code_t;                // active-low g..a

    function automatic seg_code_t hex_to_seg(input logic [3:0] nib);
        seg_code_t seg;
        case (nib)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011;                 // lower case b
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;                 // lower case d
            4'he: seg = 7'b0000110;
            default: seg = 7'b0001110;              // F
        endcase
        return seg;
    endfunction

endpackage

// ==== uart_loader.sv ====
`timescale 1ns/100ps

module uart_loader import soc_pkg::*; #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rx,
    output logic      load_wr,
    output load_rec_t load_rec,
    output logic      load_done
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

    rx_state_e        state;
    logic             rx_meta, rx_sync;             // two-flop synchronizer
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic [1:0]       byte_idx;                     // 0 addr, 1 high, 2 low
    logic [7:0]       addr_byte;
    logic [7:0]       hi_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                        // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            byte_idx  <= '0;
            load_wr   <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_wr <= 1'b0;
            case (state)
                st_idle: begin
                    baud_cnt <= '0;
                    // nothing more is read once the end marker has arrived
                    if (!rx_sync && !load_done) state <= st_start;
                end
                st_start: begin
                    if (baud_cnt == CNT_HALF) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? st_idle : st_data;  // glitch check
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (baud_cnt == CNT_FULL) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (baud_cnt == CNT_FULL) begin
                        baud_cnt <= '0;
                        state    <= st_idle;
                        if (rx_sync) begin          // drop bytes with a bad stop bit
                            case (byte_idx)
                                2'd0: begin
                                    if (shift == 8'hff) begin
                                        load_done <= 1'b1;
                                    end else begin
                                        byte_idx <= 2'd1;
                                    end
                                end
                                2'd1: byte_idx <= 2'd2;
                                default: begin
                                    load_wr  <= 1'b1;
                                    byte_idx <= 2'd0;
                                end
                            endcase
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == st_data && baud_cnt == CNT_FULL) begin
            shift <= {rx_sync, shift[7:1]};         // lsb arrives first
        end
        if (state == st_stop && baud_cnt == CNT_FULL && rx_sync) begin
            case (byte_idx)
                2'd0:    addr_byte <= shift;
                2'd1:    hi_byte   <= shift;
                default: begin
                    load_rec.addr  <= addr_byte[ADDR_W-1:0];   // upper bits ignored
                    load_rec.instr <= instr_t'({hi_byte, shift});
                end
            endcase
        end
    end

endmodule

// ==== acc_cpu.sv ====
`timescale 1ns/100ps

module acc_cpu import soc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_wr,
    input  load_rec_t load_rec,
    input  logic      load_done,
    input  disp_t     switches,
    output disp_t     out_reg,
    output logic      halted
);

    typedef enum logic [1:0] {st_wait_load, st_run, st_halt} cpu_state_e;

    instr_t            imem [MEM_DEPTH];
    cpu_state_e        state, state_d;
    logic [ADDR_W-1:0] pc, pc_d;
    disp_t             acc, acc_d;
    disp_t             out_d;
    logic              halted_d;
    instr_t            ir;
    disp_t             imm_ext;

    // loader owns the memory until the program starts
    always_ff @(posedge clk) begin
        if (load_wr && state == st_wait_load) begin
            imem[load_rec.addr] <= load_rec.instr;
        end
    end

    assign ir      = imem[pc];
    assign imm_ext = {8'h00, ir.imm};

    always_comb begin
        state_d  = state;
        pc_d     = pc;
        acc_d    = acc;
        out_d    = out_reg;
        halted_d = halted;
        case (state)
            st_wait_load: begin
                pc_d = '0;
                if (load_done) state_d = st_run;
            end
            st_run: begin
                pc_d = pc + 1'b1;                   // wraps past the last word
                case (ir.op)
                    op_ldi: acc_d = imm_ext;
                    op_add: acc_d = acc + imm_ext;
                    op_sub: acc_d = acc - imm_ext;
                    op_rsw: acc_d = switches;
                    op_out: out_d = acc;
                    op_jnz: begin
                        if (acc != '0) pc_d = ir.imm[ADDR_W-1:0];
                    end
                    op_halt: begin
                        pc_d     = pc;
                        halted_d = 1'b1;
                        state_d  = st_halt;
                    end
                    default: ;                      // unknown opcodes do nothing
                endcase
            end
            st_halt: ;                              // parked until reset
            default: state_d = st_wait_load;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_wait_load;
            pc      <= '0;
            acc     <= '0;
            out_reg <= '0;
            halted  <= 1'b0;
        end else begin
            state   <= state_d;
            pc      <= pc_d;
            acc     <= acc_d;
            out_reg <= out_d;
            halted  <= halted_d;
        end
    end

endmodule

// ==== seg7_scan.sv ====
`timescale 1ns/100ps

module seg7_scan import soc_pkg::*; #(
    parameter int SCAN_DIV = 50000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  disp_t      value,
    output logic [3:0] seg_en,
    output seg_code_t  seg_out
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       digit;                        // 0 is the rightmost nibble
    logic [3:0]       nibble;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            digit   <= '0;
        end else if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            digit   <= digit + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign nibble  = value[digit*4 +: 4];
    assign seg_en  = ~(4'b0001 << digit);          // one digit low at a time
    assign seg_out = hex_to_seg(nibble);

endmodule

// ==== soc_top.sv ====
`timescale 1ns/100ps

module soc_top import soc_pkg::*; #(
    parameter int CLKS_PER_BIT = 868,
    parameter int SCAN_DIV     = 50000
) (
    input  logic       clk,
    input  logic       rst_n,
    // serial boot line
    input  logic       rx,
    input  disp_t      switches,
    output disp_t      led_out,
    output logic [3:0] seg_en,
    output seg_code_t  seg_out,
    output logic       halted
);

    logic      load_wr;
    load_rec_t load_rec;
    logic      load_done;

    uart_loader #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_loader_inst (
        .clk,
        .rst_n,
        .rx,
        .load_wr,
        .load_rec,
        .load_done
    );

    acc_cpu acc_cpu_inst (
        .clk,
        .rst_n,
        .load_wr,
        .load_rec,
        .load_done,
        .switches,
        .out_reg(led_out),                          // also feeds the display
        .halted
    );

    seg7_scan #(
        .SCAN_DIV(SCAN_DIV)
    ) seg7_scan_inst (
        .clk,
        .rst_n,
        .value(led_out),
        .seg_en,
        .seg_out
    );

endmodule

// ==== soc_top_tb.sv ====
`timescale 1ns/100ps

module soc_top_tb import soc_pkg::*; ();

    localparam int CLKS_PER_BIT = 8;
    localparam int SCAN_DIV     = 4;

    // active-low g..a patterns of the usual hex font
    localparam seg_code_t HEX_FONT [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
        7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    typedef struct packed {
        instr_t [7:0] prog;
        int           len;
        logic         rev;                          // send records top address first
        disp_t        sw;
        disp_t        want;                         // led_out after halt
    } prog_entry_t;

    logic       clk;
    logic       rst_n;
    logic       rx;
    disp_t      switches;
    disp_t      led_out;
    logic [3:0] seg_en;
    seg_code_t  seg_out;
    logic       halted;

    prog_entry_t tbl [5];

    soc_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .SCAN_DIV(SCAN_DIV)
    ) soc_top_inst (
        .clk,
        .rst_n,
        .rx,
        .switches,
        .led_out,
        .seg_en,
        .seg_out,
        .halted
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_disp(input string name, input disp_t want, input disp_t got);
        if (got !== want) begin
            fail_run($sformatf("error at %0d ns: %s expected %h, got %h", $time, name, want, got));
        end
    endtask

    task automatic check_seg(input string name, input seg_code_t want, input seg_code_t got);
        if (got !== want) begin
            fail_run($sformatf("error at %0d ns: %s expected %b, got %b", $time, name, want, got));
        end
    endtask

    task automatic check_en(input string name, input logic [3:0] want, input logic [3:0] got);
        if (got !== want) begin
            fail_run($sformatf("error at %0d ns: %s expected %b, got %b", $time, name, want, got));
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            fail_run($sformatf("error at %0d ns: %s expected %b, got %b", $time, name, want, got));
        end
    endtask

    function automatic instr_t make_instr(input opcode_e code, input logic [7:0] val);
        return '{op: code, rsvd: 4'h0, imm: val};
    endfunction

    // reference model of the instruction rules
    // words past len act as nop
    function automatic disp_t model_run(input prog_entry_t e);
        disp_t  acc;
        disp_t  out;
        int     pc;
        int     next_pc;
        instr_t ins;
        acc = '0;
        out = '0;
        pc  = 0;
        for (int steps = 0; steps < 4000; steps++) begin
            ins     = (pc < e.len) ? e.prog[pc[2:0]] : '0;
            next_pc = (pc + 1) % MEM_DEPTH;
            case (ins.op)
                op_ldi:  acc = {8'h00, ins.imm};
                op_add:  acc = acc + {8'h00, ins.imm};
                op_sub:  acc = acc - {8'h00, ins.imm};
                op_rsw:  acc = e.sw;
                op_out:  out = acc;
                op_jnz:  if (acc != '0) next_pc = int'(ins.imm[4:0]);
                op_halt: return out;
                default: ;
            endcase
            pc = next_pc;
        end
        return out;
    endfunction

    task automatic apply_reset(input disp_t sw);
        @(posedge clk);
        rst_n    <= 1'b0;
        rx       <= 1'b1;
        switches <= sw;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};                    // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic load_program(input prog_entry_t e);
        int idx;
        for (int k = 0; k < e.len; k++) begin
            idx = e.rev ? e.len - 1 - k : k;
            send_byte(8'(idx));
            send_byte(e.prog[idx[2:0]][15:8]);
            send_byte(e.prog[idx[2:0]][7:0]);
        end
    endtask

    task automatic wait_halted(input int limit);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > limit) fail_run("timeout: halted did not rise after the program was loaded");
        end while (!halted);
    endtask

    task automatic check_scan();
        logic [3:0] prev;
        logic [3:0] seen;
        int         digit;
        int         t;
        seen = '0;
        prev = seg_en;
        for (int step = 0; step < 4; step++) begin
            t = 0;
            while (seg_en == prev) begin
                @(negedge clk);
                t++;
                if (t > 4 * SCAN_DIV) fail_run("timeout: seg_en did not change during the scan");
            end
            prev  = seg_en;
            digit = -1;
            for (int i = 0; i < 4; i++) begin
                if (seg_en == ~(4'b0001 << i)) digit = i;
            end
            if (digit < 0) begin
                fail_run($sformatf("error at %0d ns: seg_en expected one low bit, got %b",
                    $time, seg_en));
            end
            seen[digit[1:0]] = 1'b1;
            check_seg("seg_out", HEX_FONT[led_out[digit*4 +: 4]], seg_out);
        end
        check_en("digits seen", 4'hf, seen);
    endtask

    initial begin
        rst_n    <= 1'b0;
        rx       <= 1'b1;
        switches <= '0;
        void'($urandom(26));
        for (int k = 0; k < 5; k++) tbl[k] = '0;
        tbl[0].prog[0] = make_instr(op_ldi, 8'h5a);
        tbl[0].prog[1] = make_instr(op_out, 8'h00);
        tbl[0].prog[2] = make_instr(op_halt, 8'h00);
        tbl[0].len     = 3;
        tbl[0].rev     = 1'b1;
        tbl[1].prog[0] = make_instr(op_ldi, 8'h00);
        tbl[1].prog[1] = make_instr(op_sub, 8'h01);
        tbl[1].prog[2] = make_instr(op_out, 8'h00);
        tbl[1].prog[3] = make_instr(op_halt, 8'h00);
        tbl[1].len     = 4;
        tbl[2]         = tbl[1];
        tbl[2].prog[3] = make_instr(op_add, 8'h01);
        tbl[2].prog[4] = make_instr(op_out, 8'h00);
        tbl[2].prog[5] = make_instr(op_halt, 8'h00);
        tbl[2].len     = 6;
        tbl[3].prog[0] = make_instr(op_rsw, 8'h00);
        tbl[3].prog[1] = make_instr(op_add, 8'h05);
        tbl[3].prog[2] = make_instr(op_out, 8'h00);
        tbl[3].prog[3] = make_instr(op_halt, 8'h00);
        tbl[3].len     = 4;
        tbl[3].sw      = 16'($urandom);
        tbl[4].prog[0] = make_instr(op_ldi, 8'(1 + $urandom % 20));    // loop count n
        tbl[4].prog[1] = make_instr(op_out, 8'h00);
        tbl[4].prog[2] = make_instr(op_sub, 8'h01);
        tbl[4].prog[3] = make_instr(op_jnz, 8'h01);
        tbl[4].prog[4] = make_instr(op_halt, 8'h00);
        tbl[4].len     = 5;
        for (int k = 0; k < 5; k++) tbl[k].want = model_run(tbl[k]);

        // outputs right after reset
        apply_reset('0);
        check_disp("led_out", '0, led_out);
        check_bit("halted", 1'b0, halted);
        check_en("seg_en", 4'b1110, seg_en);
        // a program with no end marker must never start
        load_program(tbl[0]);
        for (int c = 0; c < 200; c++) begin
            @(negedge clk);
            check_bit("halted", 1'b0, halted);
        end

        for (int k = 0; k < 5; k++) begin
            apply_reset(tbl[k].sw);
            load_program(tbl[k]);
            send_byte(8'hff);
            wait_halted(1000);
            check_disp("led_out", tbl[k].want, led_out);
            check_scan();
            check_bit("halted", 1'b1, halted);     // still set after the scan
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== soc_top.f ====
soc_pkg.sv
uart_loader.sv
acc_cpu.sv
seg7_scan.sv
soc_top.sv
soc_top_tb.sv

// ==== Makefile ====
TOP := soc_top_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f soc_top.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
